//--- compile.f
source/xbar_pkg.sv
source/rr_arbiter.sv
source/idx_fifo.sv
source/xbar_ctrl.sv
source/req_switch.sv
source/resp_switch.sv
source/axi_xbar.sv
tests/axi_slave_model.sv
tests/tb_axi_xbar.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the crossbar testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_axi_xbar
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_axi_xbar)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1

//--- source/axi_xbar.sv
module axi_xbar #(
    parameter int NUM_MST = 2,
    parameter int NUM_SLV = 2,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      m_aw_valid [NUM_MST],
    input  xbar_pkg::ax_req_t         m_aw [NUM_MST],
    output logic                      m_aw_ready [NUM_MST],
    input  logic                      m_w_valid [NUM_MST],
    input  xbar_pkg::w_beat_t         m_w [NUM_MST],
    output logic                      m_w_ready [NUM_MST],
    output logic                      m_b_valid [NUM_MST],
    output logic [xbar_pkg::ID_W-1:0] m_b_id [NUM_MST],
    output xbar_pkg::b_payload_t      m_b [NUM_MST],
    input  logic                      m_b_ready [NUM_MST],
    input  logic                      m_ar_valid [NUM_MST],
    input  xbar_pkg::ax_req_t         m_ar [NUM_MST],
    output logic                      m_ar_ready [NUM_MST],
    output logic                      m_r_valid [NUM_MST],
    output logic [xbar_pkg::ID_W-1:0] m_r_id [NUM_MST],
    output xbar_pkg::r_payload_t      m_r [NUM_MST],
    input  logic                      m_r_ready [NUM_MST],
    output logic                      s_aw_valid [NUM_SLV],
    output xbar_pkg::s_ax_req_t       s_aw [NUM_SLV],
    input  logic                      s_aw_ready [NUM_SLV],
    output logic                      s_w_valid [NUM_SLV],
    output xbar_pkg::w_beat_t         s_w [NUM_SLV],
    input  logic                      s_w_ready [NUM_SLV],
    input  logic                      s_b_valid [NUM_SLV],
    input  xbar_pkg::sid_t            s_b_id [NUM_SLV],
    input  xbar_pkg::b_payload_t      s_b [NUM_SLV],
    output logic                      s_b_ready [NUM_SLV],
    output logic                      s_ar_valid [NUM_SLV],
    output xbar_pkg::s_ax_req_t       s_ar [NUM_SLV],
    input  logic                      s_ar_ready [NUM_SLV],
    input  logic                      s_r_valid [NUM_SLV],
    input  xbar_pkg::sid_t            s_r_id [NUM_SLV],
    input  xbar_pkg::r_payload_t      s_r [NUM_SLV],
    output logic                      s_r_ready [NUM_SLV]
);
    logic [NUM_MST-1:0] aw_grant [NUM_SLV];
    logic [NUM_MST-1:0] ar_grant [NUM_SLV];
    logic [NUM_MST-1:0] w_grant [NUM_SLV];
    xbar_pkg::addr_u    aw_addr [NUM_MST];
    xbar_pkg::addr_u    ar_addr [NUM_MST];
    logic               w_last [NUM_MST];

    always_comb begin
        for (int m = 0; m < NUM_MST; m++) begin
            aw_addr[m] = m_aw[m].addr;
            ar_addr[m] = m_ar[m].addr;
            w_last[m] = m_w[m].last;
        end
    end

    xbar_ctrl #(.NUM_MST(NUM_MST), .NUM_SLV(NUM_SLV), .FIFO_DEPTH(FIFO_DEPTH)) i_ctrl (
        .clk(clk), .reset(reset),
        .aw_valid(m_aw_valid), .aw_addr(aw_addr), .aw_ready(m_aw_ready),
        .ar_valid(m_ar_valid), .ar_addr(ar_addr), .ar_ready(m_ar_ready),
        .w_valid(m_w_valid), .w_last(w_last), .w_ready(m_w_ready),
        .aw_grant(aw_grant), .ar_grant(ar_grant), .w_grant(w_grant)
    );

    req_switch #(.NUM_MST(NUM_MST), .NUM_SLV(NUM_SLV)) i_aw_switch (
        .m_valid(m_aw_valid), .m_req(m_aw), .m_ready(m_aw_ready), .grant(aw_grant),
        .s_valid(s_aw_valid), .s_req(s_aw), .s_ready(s_aw_ready)
    );

    req_switch #(.NUM_MST(NUM_MST), .NUM_SLV(NUM_SLV)) i_ar_switch (
        .m_valid(m_ar_valid), .m_req(m_ar), .m_ready(m_ar_ready), .grant(ar_grant),
        .s_valid(s_ar_valid), .s_req(s_ar), .s_ready(s_ar_ready)
    );

    resp_switch #(
        .NUM_MST(NUM_MST), .NUM_SLV(NUM_SLV),
        .payload_t(xbar_pkg::b_payload_t), .BURST(1'b0)
    ) i_b_switch (
        .clk(clk), .reset(reset),
        .s_valid(s_b_valid), .s_id(s_b_id), .s_payload(s_b), .s_ready(s_b_ready),
        .m_valid(m_b_valid), .m_id(m_b_id), .m_payload(m_b), .m_ready(m_b_ready)
    );

    resp_switch #(
        .NUM_MST(NUM_MST), .NUM_SLV(NUM_SLV),
        .payload_t(xbar_pkg::r_payload_t), .BURST(1'b1)
    ) i_r_switch (
        .clk(clk), .reset(reset),
        .s_valid(s_r_valid), .s_id(s_r_id), .s_payload(s_r), .s_ready(s_r_ready),
        .m_valid(m_r_valid), .m_id(m_r_id), .m_payload(m_r), .m_ready(m_r_ready)
    );

    // W beats follow the FIFO pairing
    always_comb begin
        for (int s = 0; s < NUM_SLV; s++) begin
            s_w_valid[s] = 1'b0;
            s_w[s] = '0;
            for (int m = 0; m < NUM_MST; m++) begin
                if (w_grant[s][m]) begin
                    s_w_valid[s] = m_w_valid[m];
                    s_w[s] = m_w[m];
                end
            end
        end
    end

    always_comb begin
        for (int m = 0; m < NUM_MST; m++) begin
            m_w_ready[m] = 1'b0;
            for (int s = 0; s < NUM_SLV; s++) begin
                m_w_ready[m] = m_w_ready[m] || (w_grant[s][m] && s_w_ready[s]);
            end
        end
    end

endmodule

//--- source/idx_fifo.sv
module idx_fifo #(
    parameter int WIDTH = 1,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             push,
    input  logic [WIDTH-1:0] push_idx,
    input  logic             pop,
    output logic [WIDTH-1:0] head_idx,
    output logic             empty,
    output logic             full
);
    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = PW + 1;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PW-1:0]    wr_ptr;
    logic [PW-1:0]    rd_ptr;
    logic [CW-1:0]    count;

    assign head_idx = mem[rd_ptr];
    assign empty = (count == '0);
    assign full = (count == CW'(DEPTH));

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_idx;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CW'(push) - CW'(pop);
        end
    end

    // AW gating upstream must keep these from happening
    assert property (@(posedge clk) disable iff (reset) push |-> !full);

    assert property (@(posedge clk) disable iff (reset) pop |-> !empty);

endmodule

//--- source/req_switch.sv
module req_switch #(
    parameter int NUM_MST = 2,
    parameter int NUM_SLV = 2
) (
    input  logic                m_valid [NUM_MST],
    input  xbar_pkg::ax_req_t   m_req [NUM_MST],
    output logic                m_ready [NUM_MST],
    input  logic [NUM_MST-1:0]  grant [NUM_SLV],
    output logic                s_valid [NUM_SLV],
    output xbar_pkg::s_ax_req_t s_req [NUM_SLV],
    input  logic                s_ready [NUM_SLV]
);
    localparam int MW = xbar_pkg::MST_IDX_W;

    // granted master's request, id widened with its index
    always_comb begin
        for (int s = 0; s < NUM_SLV; s++) begin
            s_valid[s] = 1'b0;
            s_req[s] = '0;
            for (int m = 0; m < NUM_MST; m++) begin
                if (grant[s][m]) begin
                    s_valid[s] = m_valid[m];
                    s_req[s].sid.mst = MW'(m);
                    s_req[s].sid.id = m_req[m].id;
                    s_req[s].addr = m_req[m].addr;
                    s_req[s].len = m_req[m].len;
                end
            end
        end
    end

    // ready back to the granted master only
    always_comb begin
        for (int m = 0; m < NUM_MST; m++) begin
            m_ready[m] = 1'b0;
            for (int s = 0; s < NUM_SLV; s++) begin
                m_ready[m] = m_ready[m] || (grant[s][m] && s_ready[s]);
            end
        end
    end

endmodule

//--- source/resp_switch.sv
module resp_switch #(
    parameter int  NUM_MST = 2,
    parameter int  NUM_SLV = 2,
    parameter type payload_t = xbar_pkg::b_payload_t,
    parameter bit  BURST = 1'b0
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        s_valid [NUM_SLV],
    input  xbar_pkg::sid_t              s_id [NUM_SLV],
    input  payload_t                    s_payload [NUM_SLV],
    output logic                        s_ready [NUM_SLV],
    output logic                        m_valid [NUM_MST],
    output logic [xbar_pkg::ID_W-1:0]   m_id [NUM_MST],
    output payload_t                    m_payload [NUM_MST],
    input  logic                        m_ready [NUM_MST]
);
    localparam int MW = xbar_pkg::MST_IDX_W;

    logic [NUM_SLV-1:0] req [NUM_MST];
    logic [NUM_SLV-1:0] grant [NUM_MST];

    // head of the sid names the master
    always_comb begin
        for (int m = 0; m < NUM_MST; m++) begin
            for (int s = 0; s < NUM_SLV; s++) begin
                req[m][s] = s_valid[s] && s_id[s].mst == MW'(m);
            end
        end
    end

    always_comb begin
        for (int m = 0; m < NUM_MST; m++) begin
            m_valid[m] = 1'b0;
            m_id[m] = '0;
            m_payload[m] = '0;
            for (int s = 0; s < NUM_SLV; s++) begin
                if (grant[m][s]) begin
                    m_valid[m] = s_valid[s];
                    m_id[m] = s_id[s].id;
                    m_payload[m] = s_payload[s];
                end
            end
        end
    end

    always_comb begin
        for (int s = 0; s < NUM_SLV; s++) begin
            s_ready[s] = 1'b0;
            for (int m = 0; m < NUM_MST; m++) begin
                s_ready[s] = s_ready[s] || (grant[m][s] && m_ready[m]);
            end
        end
    end

    for (genvar m = 0; m < NUM_MST; m++) begin : g_mst
        logic busy;

        if (BURST) begin : g_burst
            // keep the slave until its last beat is taken
            always_ff @(posedge clk) begin
                if (reset) begin
                    busy <= 1'b0;
                end else if (m_valid[m] && m_ready[m]) begin
                    busy <= !m_payload[m].last;
                end
            end
        end else begin : g_single
            assign busy = 1'b0;
        end

        rr_arbiter #(.NUM(NUM_SLV)) i_arb (
            .clk(clk), .reset(reset), .req(req[m]), .hold(busy),
            .accept(m_valid[m] && m_ready[m]), .grant(grant[m])
        );
    end

endmodule

//--- source/rr_arbiter.sv
module rr_arbiter #(
    parameter int NUM = 2
) (
    input  logic           clk,
    input  logic           reset,
    input  logic [NUM-1:0] req,
    input  logic           hold,
    input  logic           accept,
    output logic [NUM-1:0] grant
);
    localparam int PW = (NUM > 1) ? $clog2(NUM) : 1;

    logic [PW-1:0]  prio;
    logic [PW-1:0]  held_idx;
    logic [PW-1:0]  win;
    logic [PW-1:0]  cur;
    logic [NUM-1:0] search;
    logic           pending;
    logic           sticky;

    // first requester at or after the pointer
    always_comb begin
        int idx;
        search = '0;
        win = prio;
        for (int i = NUM - 1; i >= 0; i--) begin
            idx = (int'(prio) + i) % NUM;
            if (req[idx]) begin
                search = '0;
                search[idx] = 1'b1;
                win = PW'(idx);
            end
        end
    end

    // an offered grant is kept until taken, or through a burst
    assign sticky = hold || pending;
    assign cur = sticky ? held_idx : win;

    always_comb begin
        grant = search;
        if (sticky) begin
            grant = '0;
            grant[held_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prio <= '0;
            held_idx <= '0;
            pending <= 1'b0;
        end else begin
            pending <= |(grant & req) && !accept;
            if (|grant) begin
                held_idx <= cur;
            end
            // winner drops to lowest priority
            if (accept) begin
                prio <= (cur == PW'(NUM - 1)) ? '0 : cur + 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) $onehot0(grant));

endmodule

//--- source/xbar_ctrl.sv
module xbar_ctrl #(
    parameter int NUM_MST = 2,
    parameter int NUM_SLV = 2,
    parameter int FIFO_DEPTH = 4
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               aw_valid [NUM_MST],
    input  xbar_pkg::addr_u    aw_addr [NUM_MST],
    input  logic               aw_ready [NUM_MST],
    input  logic               ar_valid [NUM_MST],
    input  xbar_pkg::addr_u    ar_addr [NUM_MST],
    input  logic               ar_ready [NUM_MST],
    input  logic               w_valid [NUM_MST],
    input  logic               w_last [NUM_MST],
    input  logic               w_ready [NUM_MST],
    output logic [NUM_MST-1:0] aw_grant [NUM_SLV],
    output logic [NUM_MST-1:0] ar_grant [NUM_SLV],
    output logic [NUM_MST-1:0] w_grant [NUM_SLV]
);
    localparam int SW = xbar_pkg::SLV_IDX_W;
    localparam int MW = xbar_pkg::MST_IDX_W;

    logic [NUM_MST-1:0] aw_hs;
    logic [NUM_MST-1:0] ar_hs;
    logic [NUM_MST-1:0] w_done;
    logic [NUM_MST-1:0] mst_full;
    logic [NUM_MST-1:0] mst_empty;
    logic [SW-1:0]      mst_head [NUM_MST];
    logic [NUM_SLV-1:0] slv_full;
    logic [NUM_SLV-1:0] slv_empty;
    logic [NUM_SLV-1:0] slv_push;
    logic [NUM_SLV-1:0] slv_pop;
    logic [MW-1:0]      slv_head [NUM_SLV];
    logic [MW-1:0]      slv_push_idx [NUM_SLV];
    logic [NUM_MST-1:0] aw_req [NUM_SLV];
    logic [NUM_MST-1:0] ar_req [NUM_SLV];

    // region decode, AW waits while either ordering FIFO is full
    always_comb begin
        for (int s = 0; s < NUM_SLV; s++) begin
            for (int m = 0; m < NUM_MST; m++) begin
                aw_req[s][m] = aw_valid[m] && aw_addr[m].f.region == SW'(s)
                    && !mst_full[m] && !slv_full[s];
                ar_req[s][m] = ar_valid[m] && ar_addr[m].f.region == SW'(s);
            end
        end
    end

    always_comb begin
        for (int m = 0; m < NUM_MST; m++) begin
            aw_hs[m] = aw_valid[m] && aw_ready[m];
            ar_hs[m] = ar_valid[m] && ar_ready[m];
            w_done[m] = w_valid[m] && w_ready[m] && w_last[m];
        end
    end

    // W passes only where both FIFO heads point at each other
    always_comb begin
        for (int s = 0; s < NUM_SLV; s++) begin
            slv_push[s] = |(aw_grant[s] & aw_hs);
            slv_push_idx[s] = '0;
            for (int m = 0; m < NUM_MST; m++) begin
                if (aw_grant[s][m]) begin
                    slv_push_idx[s] = MW'(m);
                end
                w_grant[s][m] = !slv_empty[s] && !mst_empty[m]
                    && slv_head[s] == MW'(m) && mst_head[m] == SW'(s);
            end
            slv_pop[s] = |(w_grant[s] & w_done);
        end
    end

    for (genvar m = 0; m < NUM_MST; m++) begin : g_mst
        // slave order of this master's writes
        idx_fifo #(.WIDTH(SW), .DEPTH(FIFO_DEPTH)) i_fifo (
            .clk(clk), .reset(reset),
            .push(aw_hs[m]), .push_idx(aw_addr[m].f.region), .pop(w_done[m]),
            .head_idx(mst_head[m]), .empty(mst_empty[m]), .full(mst_full[m])
        );

        assert property (@(posedge clk) disable iff (reset)
            aw_valid[m] |-> int'(aw_addr[m].f.region) < NUM_SLV);

        assert property (@(posedge clk) disable iff (reset)
            ar_valid[m] |-> int'(ar_addr[m].f.region) < NUM_SLV);
    end

    for (genvar s = 0; s < NUM_SLV; s++) begin : g_slv
        // master order of the writes this slave accepted
        idx_fifo #(.WIDTH(MW), .DEPTH(FIFO_DEPTH)) i_fifo (
            .clk(clk), .reset(reset),
            .push(slv_push[s]), .push_idx(slv_push_idx[s]), .pop(slv_pop[s]),
            .head_idx(slv_head[s]), .empty(slv_empty[s]), .full(slv_full[s])
        );

        rr_arbiter #(.NUM(NUM_MST)) i_aw_arb (
            .clk(clk), .reset(reset), .req(aw_req[s]), .hold(1'b0),
            .accept(slv_push[s]), .grant(aw_grant[s])
        );

        rr_arbiter #(.NUM(NUM_MST)) i_ar_arb (
            .clk(clk), .reset(reset), .req(ar_req[s]), .hold(1'b0),
            .accept(|(ar_grant[s] & ar_hs)), .grant(ar_grant[s])
        );
    end

endmodule

//--- source/xbar_pkg.sv
package xbar_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int ID_W = 4;
    localparam int MST_IDX_W = 1;
    localparam int SLV_IDX_W = 1;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    typedef logic [ADDR_W-1:0] addr_t;

    // region bits on top select the slave
    typedef struct packed {
        logic [SLV_IDX_W-1:0]        region;
        logic [ADDR_W-SLV_IDX_W-1:0] offset;
    } addr_fields_t;

    typedef union packed {
        addr_t        raw;
        addr_fields_t f;
    } addr_u;

    // slave-side id, master index in front
    typedef struct packed {
        logic [MST_IDX_W-1:0] mst;
        logic [ID_W-1:0]      id;
    } sid_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
        addr_u           addr;
        logic [7:0]      len;
    } ax_req_t;

    typedef struct packed {
        sid_t       sid;
        addr_u      addr;
        logic [7:0] len;
    } s_ax_req_t;

    typedef struct packed {
        logic [DATA_W-1:0]   data;
        logic [DATA_W/8-1:0] strb;
        logic                last;
    } w_beat_t;

    typedef struct packed {
        logic [1:0] resp;
    } b_payload_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
        logic              last;
    } r_payload_t;

endpackage

//--- tests/axi_slave_model.sv
module axi_slave_model (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  aw_stall,
    input  logic                  ar_stall,
    input  logic                  aw_valid,
    input  xbar_pkg::s_ax_req_t   aw,
    output logic                  aw_ready,
    input  logic                  w_valid,
    input  xbar_pkg::w_beat_t     w,
    output logic                  w_ready,
    output logic                  b_valid,
    output xbar_pkg::sid_t        b_id,
    output xbar_pkg::b_payload_t  b,
    input  logic                  b_ready,
    input  logic                  ar_valid,
    input  xbar_pkg::s_ax_req_t   ar,
    output logic                  ar_ready,
    output logic                  r_valid,
    output xbar_pkg::sid_t        r_id,
    output xbar_pkg::r_payload_t  r,
    input  logic                  r_ready
);
    logic [31:0]    mem [64];
    logic           wr_busy;
    logic [5:0]     wr_ptr;
    xbar_pkg::sid_t wr_sid;
    logic           rd_busy;
    logic [5:0]     rd_ptr;
    logic [7:0]     rd_left;
    xbar_pkg::sid_t aw_log [16];
    int             aw_count;

    // one write and one read in flight at a time
    assign aw_ready = !wr_busy && !aw_stall;
    assign w_ready = wr_busy && !b_valid;
    assign ar_ready = !rd_busy && !ar_stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_busy <= 1'b0;
            wr_ptr <= '0;
            wr_sid <= '0;
            b_valid <= 1'b0;
            b_id <= '0;
            b <= '0;
            aw_count <= 0;
            for (int i = 0; i < 64; i++) begin
                mem[i] <= '0;
            end
        end else begin
            if (aw_valid && aw_ready) begin
                wr_busy <= 1'b1;
                wr_ptr <= aw.addr.f.offset[7:2];
                wr_sid <= aw.sid;
                aw_log[aw_count] <= aw.sid;
                aw_count <= aw_count + 1;
            end
            if (w_valid && w_ready) begin
                mem[wr_ptr] <= w.data;
                wr_ptr <= wr_ptr + 6'd1;
                if (w.last) begin
                    b_valid <= 1'b1;
                    b_id <= wr_sid;
                    b.resp <= xbar_pkg::RESP_OKAY;
                end
            end
            if (b_valid && b_ready) begin
                b_valid <= 1'b0;
                wr_busy <= 1'b0;
            end
        end
    end

    // len+1 beats, word address counts up from the AR offset
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_busy <= 1'b0;
            rd_ptr <= '0;
            rd_left <= '0;
            r_valid <= 1'b0;
            r_id <= '0;
            r <= '0;
        end else begin
            if (ar_valid && ar_ready) begin
                rd_busy <= 1'b1;
                rd_ptr <= ar.addr.f.offset[7:2];
                rd_left <= ar.len;
                r_valid <= 1'b1;
                r_id <= ar.sid;
                r.data <= mem[ar.addr.f.offset[7:2]];
                r.resp <= xbar_pkg::RESP_OKAY;
                r.last <= (ar.len == 8'd0);
            end
            if (r_valid && r_ready) begin
                if (r.last) begin
                    r_valid <= 1'b0;
                    rd_busy <= 1'b0;
                end else begin
                    rd_ptr <= rd_ptr + 6'd1;
                    rd_left <= rd_left - 8'd1;
                    r.data <= mem[rd_ptr + 6'd1];
                    r.last <= (rd_left == 8'd1);
                end
            end
        end
    end

endmodule

//--- tests/tb_axi_xbar.sv
module tb_axi_xbar;
    localparam int NUM_MST = 2;
    localparam int NUM_SLV = 2;
    // reset plus five short tests stay well below a few hundred cycles
    localparam int MAX_CYCLES = 2000;

    logic clk = 1'b0;
    logic reset;
    logic aw_stall [NUM_SLV];
    logic ar_stall [NUM_SLV];

    logic                      m_aw_valid [NUM_MST];
    xbar_pkg::ax_req_t         m_aw [NUM_MST];
    logic                      m_aw_ready [NUM_MST];
    logic                      m_w_valid [NUM_MST];
    xbar_pkg::w_beat_t         m_w [NUM_MST];
    logic                      m_w_ready [NUM_MST];
    logic                      m_b_valid [NUM_MST];
    logic [xbar_pkg::ID_W-1:0] m_b_id [NUM_MST];
    xbar_pkg::b_payload_t      m_b [NUM_MST];
    logic                      m_b_ready [NUM_MST];
    logic                      m_ar_valid [NUM_MST];
    xbar_pkg::ax_req_t         m_ar [NUM_MST];
    logic                      m_ar_ready [NUM_MST];
    logic                      m_r_valid [NUM_MST];
    logic [xbar_pkg::ID_W-1:0] m_r_id [NUM_MST];
    xbar_pkg::r_payload_t      m_r [NUM_MST];
    logic                      m_r_ready [NUM_MST];

    logic                      s_aw_valid [NUM_SLV];
    xbar_pkg::s_ax_req_t       s_aw [NUM_SLV];
    logic                      s_aw_ready [NUM_SLV];
    logic                      s_w_valid [NUM_SLV];
    xbar_pkg::w_beat_t         s_w [NUM_SLV];
    logic                      s_w_ready [NUM_SLV];
    logic                      s_b_valid [NUM_SLV];
    xbar_pkg::sid_t            s_b_id [NUM_SLV];
    xbar_pkg::b_payload_t      s_b [NUM_SLV];
    logic                      s_b_ready [NUM_SLV];
    logic                      s_ar_valid [NUM_SLV];
    xbar_pkg::s_ax_req_t       s_ar [NUM_SLV];
    logic                      s_ar_ready [NUM_SLV];
    logic                      s_r_valid [NUM_SLV];
    xbar_pkg::sid_t            s_r_id [NUM_SLV];
    xbar_pkg::r_payload_t      s_r [NUM_SLV];
    logic                      s_r_ready [NUM_SLV];

    int          errors = 0;
    int          cycles = 0;
    // expected next AW winner at each slave
    int          aw_prio [NUM_SLV];
    logic [31:0] wdata [NUM_MST][4];
    logic [31:0] shadow [logic [31:0]];

    axi_xbar #(.NUM_MST(NUM_MST), .NUM_SLV(NUM_SLV), .FIFO_DEPTH(4)) i_dut (
        .clk(clk), .reset(reset),
        .m_aw_valid(m_aw_valid), .m_aw(m_aw), .m_aw_ready(m_aw_ready),
        .m_w_valid(m_w_valid), .m_w(m_w), .m_w_ready(m_w_ready),
        .m_b_valid(m_b_valid), .m_b_id(m_b_id), .m_b(m_b), .m_b_ready(m_b_ready),
        .m_ar_valid(m_ar_valid), .m_ar(m_ar), .m_ar_ready(m_ar_ready),
        .m_r_valid(m_r_valid), .m_r_id(m_r_id), .m_r(m_r), .m_r_ready(m_r_ready),
        .s_aw_valid(s_aw_valid), .s_aw(s_aw), .s_aw_ready(s_aw_ready),
        .s_w_valid(s_w_valid), .s_w(s_w), .s_w_ready(s_w_ready),
        .s_b_valid(s_b_valid), .s_b_id(s_b_id), .s_b(s_b), .s_b_ready(s_b_ready),
        .s_ar_valid(s_ar_valid), .s_ar(s_ar), .s_ar_ready(s_ar_ready),
        .s_r_valid(s_r_valid), .s_r_id(s_r_id), .s_r(s_r), .s_r_ready(s_r_ready)
    );

    for (genvar s = 0; s < NUM_SLV; s++) begin : g_slv
        axi_slave_model i_slv (
            .clk(clk), .reset(reset), .aw_stall(aw_stall[s]), .ar_stall(ar_stall[s]),
            .aw_valid(s_aw_valid[s]), .aw(s_aw[s]), .aw_ready(s_aw_ready[s]),
            .w_valid(s_w_valid[s]), .w(s_w[s]), .w_ready(s_w_ready[s]),
            .b_valid(s_b_valid[s]), .b_id(s_b_id[s]), .b(s_b[s]), .b_ready(s_b_ready[s]),
            .ar_valid(s_ar_valid[s]), .ar(s_ar[s]), .ar_ready(s_ar_ready[s]),
            .r_valid(s_r_valid[s]), .r_id(s_r_id[s]), .r(s_r[s]), .r_ready(s_r_ready[s])
        );
    end

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic check_b(input xbar_pkg::b_payload_t got, input xbar_pkg::b_payload_t exp,
                           input string what);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_r(input xbar_pkg::r_payload_t got, input xbar_pkg::r_payload_t exp,
                           input string what);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_id(input logic [xbar_pkg::ID_W-1:0] got,
                            input logic [xbar_pkg::ID_W-1:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_sid(input xbar_pkg::sid_t got, input xbar_pkg::sid_t exp,
                             input string what);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic fill_data(input int m);
        for (int i = 0; i < 4; i++) begin
            wdata[m][i] = $urandom();
        end
    endtask

    // AW then W beats from wdata then B
    // starts and ends on a rising edge
    task automatic do_write(input int m, input logic [3:0] id, input logic [31:0] addr,
                            input int len, input int b_delay);
        xbar_pkg::ax_req_t    req;
        xbar_pkg::w_beat_t    beat;
        xbar_pkg::b_payload_t exp_b;
        req.id = id;
        req.addr.raw = addr;
        req.len = 8'(len);
        exp_b.resp = xbar_pkg::RESP_OKAY;
        m_aw[m] <= req;
        m_aw_valid[m] <= 1'b1;
        do @(negedge clk); while (!m_aw_ready[m]);
        @(posedge clk);
        m_aw_valid[m] <= 1'b0;
        aw_prio[req.addr.f.region] = (m + 1) % NUM_MST;
        for (int i = 0; i <= len; i++) begin
            beat.data = wdata[m][i];
            beat.strb = '1;
            beat.last = (i == len);
            m_w[m] <= beat;
            m_w_valid[m] <= 1'b1;
            do @(negedge clk); while (!m_w_ready[m]);
            @(posedge clk);
            shadow[addr + 32'(4 * i)] = wdata[m][i];
        end
        m_w_valid[m] <= 1'b0;
        do @(negedge clk); while (!m_b_valid[m]);
        // B is held for b_delay cycles before ready goes high
        for (int i = 0; i <= b_delay; i++) begin
            if (i > 0) begin
                @(negedge clk);
            end
            if (!m_b_valid[m]) begin
                errors++;
                $display("master %0d B valid dropped before it was accepted", m);
            end
            check_id(m_b_id[m], id, "BID");
            check_b(m_b[m], exp_b, "BRESP");
        end
        @(posedge clk);
        m_b_ready[m] <= 1'b1;
        @(posedge clk);
        m_b_ready[m] <= 1'b0;
    endtask

    task automatic do_read(input int m, input logic [3:0] id, input logic [31:0] addr,
                           input int len);
        xbar_pkg::ax_req_t    req;
        xbar_pkg::r_payload_t exp_r;
        logic [31:0]          a;
        req.id = id;
        req.addr.raw = addr;
        req.len = 8'(len);
        m_ar[m] <= req;
        m_ar_valid[m] <= 1'b1;
        do @(negedge clk); while (!m_ar_ready[m]);
        @(posedge clk);
        m_ar_valid[m] <= 1'b0;
        m_r_ready[m] <= 1'b1;
        for (int i = 0; i <= len; i++) begin
            a = addr + 32'(4 * i);
            // unwritten words read as zero
            exp_r.data = shadow.exists(a) ? shadow[a] : '0;
            exp_r.resp = xbar_pkg::RESP_OKAY;
            exp_r.last = (i == len);
            do @(negedge clk); while (!m_r_valid[m]);
            check_id(m_r_id[m], id, "RID");
            check_r(m_r[m], exp_r, "R beat");
            @(posedge clk);
        end
        m_r_ready[m] <= 1'b0;
    endtask

    // the master sees no ready while the slave stalls
    task automatic stall_and_release(input int m, input int s, input bit on_aw);
        if (on_aw) begin
            aw_stall[s] <= 1'b1;
        end else begin
            ar_stall[s] <= 1'b1;
        end
        repeat (5) begin
            @(negedge clk);
            if (on_aw ? m_aw_ready[m] : m_ar_ready[m]) begin
                errors++;
                $display("master %0d request was accepted while slave %0d stalled it", m, s);
            end
        end
        @(posedge clk);
        if (on_aw) begin
            aw_stall[s] <= 1'b0;
        end else begin
            ar_stall[s] <= 1'b0;
        end
    endtask

    task automatic test_write_read();
        fill_data(0);
        do_write(0, 4'h3, 32'h0000_0010, 0, 0);
        fill_data(0);
        do_write(0, 4'h5, 32'h8000_0020, 0, 0);
        do_read(0, 4'h6, 32'h0000_0010, 0);
        do_read(0, 4'h7, 32'h8000_0020, 0);
    endtask

    task automatic test_routing();
        int             n0;
        int             n1;
        xbar_pkg::sid_t exp_sid;
        n0 = g_slv[0].i_slv.aw_count;
        n1 = g_slv[1].i_slv.aw_count;
        fill_data(1);
        do_write(1, 4'hA, 32'h8000_0030, 0, 0);
        exp_sid.mst = 1'b1;
        exp_sid.id = 4'hA;
        check_sid(g_slv[1].i_slv.aw_log[n1], exp_sid, "slave 1 AW sid");
        if (g_slv[1].i_slv.aw_count != n1 + 1) begin
            errors++;
            $display("slave 1 did not see exactly one AW from master 1");
        end
        if (g_slv[0].i_slv.aw_count != n0) begin
            errors++;
            $display("slave 0 received an AW that was meant for slave 1");
        end
    endtask

    task automatic test_arbitration();
        int             base;
        int             first;
        xbar_pkg::sid_t exp_sid;
        base = g_slv[0].i_slv.aw_count;
        first = aw_prio[0];
        fill_data(0);
        fill_data(1);
        fork
            do_write(0, 4'h1, 32'h0000_0040, 0, 0);
            do_write(1, 4'h2, 32'h0000_0044, 0, 0);
        join
        exp_sid.mst = 1'(first);
        exp_sid.id = 4'(first + 1);
        check_sid(g_slv[0].i_slv.aw_log[base], exp_sid, "first AW at slave 0");
        exp_sid.mst = 1'(1 - first);
        exp_sid.id = 4'(2 - first);
        check_sid(g_slv[0].i_slv.aw_log[base + 1], exp_sid, "second AW at slave 0");
    endtask

    task automatic test_burst();
        fill_data(0);
        do_write(0, 4'h9, 32'h0000_0080, 3, 0);
        do_read(0, 4'h9, 32'h0000_0080, 3);
    endtask

    task automatic test_back_pressure();
        fill_data(1);
        fork
            do_write(1, 4'hC, 32'h0000_0008, 0, 5);
            stall_and_release(1, 0, 1'b1);
        join
        fork
            do_read(1, 4'hD, 32'h8000_0020, 0);
            stall_and_release(1, 1, 1'b0);
        join
    endtask

    initial begin
        void'($urandom(1497));
        reset = 1'b1;
        for (int m = 0; m < NUM_MST; m++) begin
            m_aw_valid[m] = 1'b0;
            m_aw[m] = '0;
            m_w_valid[m] = 1'b0;
            m_w[m] = '0;
            m_b_ready[m] = 1'b0;
            m_ar_valid[m] = 1'b0;
            m_ar[m] = '0;
            m_r_ready[m] = 1'b0;
        end
        for (int s = 0; s < NUM_SLV; s++) begin
            aw_stall[s] = 1'b0;
            ar_stall[s] = 1'b0;
            aw_prio[s] = 0;
        end
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        test_write_read();
        test_routing();
        test_arbitration();
        test_burst();
        test_back_pressure();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
